// ==== src/ahbSwitchPkg.sv ====
package ahbSwitchPkg;

  //////////////////////////////
  // Switch dimensions
  //////////////////////////////

  // Two masters and two slaves
  localparam int numMasters     = 2;
  localparam int numSlaves      = 2;
  // Bits for a master index
  localparam int masterIdxWidth = $clog2(numMasters);

  // AHB bus widths
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  //////////////////////////////
  // Bus types
  //////////////////////////////

  typedef logic [addrWidth-1:0]  addrT;
  typedef logic [dataWidth-1:0]  dataT;
  // HSIZE code
  typedef logic [2:0]            sizeT;
  // HTRANS code
  typedef logic [1:0]            transT;
  // One bit per slave port
  typedef logic [numSlaves-1:0]  slaveVecT;
  // One bit per master port
  typedef logic [numMasters-1:0] masterVecT;

  // HTRANS encodings
  localparam transT transIdle   = 2'b00;
  localparam transT transBusy   = 2'b01;
  localparam transT transNonSeq = 2'b10;
  localparam transT transSeq    = 2'b11;

  //////////////////////////////
  // Address map
  //////////////////////////////

  // Slave s is hit when (haddr & mask) equals (base & mask)
  localparam addrT slaveBase [numSlaves] = '{
    32'h0000_0000,
    32'h1000_0000
  };

  // Top nibble selects the slave
  localparam addrT slaveMask [numSlaves] = '{
    32'hF000_0000,
    32'hF000_0000
  };

  //////////////////////////////
  // Master port FSM
  //////////////////////////////

  // Idle bus, blocked address phase, data phase in flight
  typedef enum logic [1:0] {
    portIdle,
    portWait,
    portData
  } portStateT;

endpackage

// ==== src/ahbReqIf.sv ====
interface ahbReqIf;
  import ahbSwitchPkg::*;

  // Target slave of a valid or held NONSEQ/SEQ transfer
  slaveVecT req;

  // Address phase as the slave should see it
  addrT     haddr;
  logic     hwrite;
  sizeT     hsize;
  transT    htrans;

  // Write data of the master's data phase
  dataT     hwdata;

  // Address phase moves this cycle
  logic     hreadyIn;

  // Low inside a burst
  logic     canSwitch;

  // Driven by the master port
  modport source (output req, haddr, hwdata, hwrite, hsize, htrans, hreadyIn, canSwitch);

  // Read by every slave port
  modport sink (input req, haddr, hwdata, hwrite, hsize, htrans, hreadyIn, canSwitch);

endinterface

// ==== src/ahbRspIf.sv ====
interface ahbRspIf;
  import ahbSwitchPkg::*;

  // Slave response, straight from the slave
  dataT      hrdata;
  logic      hreadyout;
  logic      hresp;

  // One-hot owner of the slave
  masterVecT grant;

  // Driven by the slave port
  modport source (output hrdata, hreadyout, hresp, grant);

  // Read by every master port
  modport sink (input hrdata, hreadyout, hresp, grant);

endinterface

// ==== src/ahbSlaveArbiter.sv ====
module ahbSlaveArbiter (
  input  logic                    hclk,
  input  logic                    rstN,
  input  ahbSwitchPkg::masterVecT req,
  input  ahbSwitchPkg::masterVecT canSwitch,
  input  logic                    slvReady,
  output ahbSwitchPkg::masterVecT grant
);
  import ahbSwitchPkg::*;

  // One-hot owner of the slave
  masterVecT grantQ;
  // Highest priority requester
  masterVecT winner;
  // Owner is between transfers on this slave
  logic      ownerFree;
  logic      moveGrant;

  //////////////////////////////
  // Priority pick
  //////////////////////////////

  // Scan downward so master 0 ends up on top
  always_comb
  begin
    winner = '0;
    for (int m = numMasters - 1; m >= 0; m--)
    begin
      if (req[m])
        winner = masterVecT'(1) << m;
    end
  end

  // Owner outside a burst
  // and no longer presenting a transfer to this slave
  // so a burst that opens with NONSEQ is never cut after its first beat
  assign ownerFree = |(grantQ & canSwitch) && !(|(grantQ & req));

  // Only at a transfer boundary with the slave ready
  assign moveGrant = slvReady && ownerFree && (|req);

  //////////////////////////////
  // Grant register
  //////////////////////////////

  always_ff @(posedge hclk or negedge rstN)
  begin
    if (!rstN)
      grantQ <= masterVecT'(1);
    else if (moveGrant)
      grantQ <= winner;
  end

  // No request leaves the grant where it is
  assign grant = grantQ;

endmodule

// ==== src/ahbMasterPort.sv ====
module ahbMasterPort (
  input  logic                    hclk,
  input  logic                    rstN,
  input  ahbSwitchPkg::masterVecT masterId,
  input  logic                    hsel,
  input  ahbSwitchPkg::addrT      haddr,
  input  ahbSwitchPkg::dataT      hwdata,
  input  logic                    hwrite,
  input  ahbSwitchPkg::sizeT      hsize,
  input  ahbSwitchPkg::transT     htrans,
  input  logic                    hready,
  output ahbSwitchPkg::dataT      hrdata,
  output logic                    hreadyout,
  output logic                    hresp,
  ahbReqIf.source                 reqBus,
  ahbRspIf.sink                   rspBus [ahbSwitchPkg::numSlaves]
);
  import ahbSwitchPkg::*;

  portStateT stateQ;
  portStateT stateNext;

  // Live address phase
  logic      liveValid;
  slaveVecT  liveSel;
  logic      liveGranted;

  // Blocked address phase
  addrT      heldAddr;
  logic      heldWrite;
  sizeT      heldSize;
  transT     heldTrans;
  slaveVecT  heldSel;
  logic      heldGranted;
  logic      holdLoad;

  // Slave serving our data phase
  slaveVecT  dataSel;

  // Flattened response buses
  slaveVecT  grantedTo;
  dataT      slvRdata [numSlaves];
  slaveVecT  slvReady;
  slaveVecT  slvResp;

  // SEQ or BUSY means we sit inside a burst
  function automatic logic inBurst(transT t);
    return (t == transSeq) || (t == transBusy);
  endfunction

  for (genvar s = 0; s < numSlaves; s++)
  begin : genSlave
    assign grantedTo[s] = |(rspBus[s].grant & masterId);
    assign slvRdata[s]  = rspBus[s].hrdata;
    assign slvReady[s]  = rspBus[s].hreadyout;
    assign slvResp[s]   = rspBus[s].hresp;
    // Fixed base and mask decode
    assign liveSel[s]   = (haddr & slaveMask[s]) == (slaveBase[s] & slaveMask[s]);
  end

  assign liveValid   = hsel && (htrans == transNonSeq || htrans == transSeq);
  assign liveGranted = |(liveSel & grantedTo);
  assign heldGranted = |(heldSel & grantedTo);

  // Master moves on but its slave belongs to the other master
  assign holdLoad = (stateQ != portWait) && hready && liveValid && !liveGranted;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb
  begin
    stateNext = stateQ;
    case (stateQ)
      portWait:
      begin
        // Grant visible so the slave takes the held phase now
        if (heldGranted)
          stateNext = portData;
      end
      default:
      begin
        if (hready)
        begin
          if (!liveValid)
            stateNext = portIdle;
          else if (liveGranted)
            stateNext = portData;
          else
            stateNext = portWait;
        end
      end
    endcase
  end

  always_ff @(posedge hclk or negedge rstN)
  begin
    if (!rstN)
    begin
      stateQ  <= portIdle;
      dataSel <= '0;
      heldSel <= '0;
    end
    else
    begin
      stateQ <= stateNext;
      if (holdLoad)
        heldSel <= liveSel;
      // Remember who answers the data phase
      if (stateQ == portWait && heldGranted)
        dataSel <= heldSel;
      else if (stateQ != portWait && hready && liveValid && liveGranted)
        dataSel <= liveSel;
    end
  end

  // Held address phase payload
  always_ff @(posedge hclk)
  begin
    if (holdLoad)
    begin
      heldAddr  <= haddr;
      heldWrite <= hwrite;
      heldSize  <= hsize;
      heldTrans <= htrans;
    end
  end

  //////////////////////////////
  // Toward the slave ports
  //////////////////////////////

  always_comb
  begin
    if (stateQ == portWait)
    begin
      reqBus.req       = heldSel;
      reqBus.haddr     = heldAddr;
      reqBus.hwrite    = heldWrite;
      reqBus.hsize     = heldSize;
      reqBus.htrans    = heldTrans;
      // Already accepted on the master side
      reqBus.hreadyIn  = 1'b1;
      reqBus.canSwitch = !inBurst(heldTrans);
    end
    else
    begin
      reqBus.req       = liveValid ? liveSel : '0;
      reqBus.haddr     = haddr;
      reqBus.hwrite    = hwrite;
      reqBus.hsize     = hsize;
      reqBus.htrans    = htrans;
      reqBus.hreadyIn  = hready;
      reqBus.canSwitch = !(hsel && inBurst(htrans));
    end
  end

  // Write data always belongs to the running data phase
  assign reqBus.hwdata = hwdata;

  // Response of the data-phase slave, stretched while blocked
  always_comb
  begin
    hrdata    = '0;
    hreadyout = 1'b1;
    hresp     = 1'b0;
    if (stateQ == portWait)
      hreadyout = 1'b0;
    else if (stateQ == portData)
    begin
      for (int s = 0; s < numSlaves; s++)
      begin
        if (dataSel[s])
        begin
          hrdata    = slvRdata[s];
          hreadyout = slvReady[s];
          hresp     = slvResp[s];
        end
      end
    end
  end

endmodule

// ==== src/ahbSlavePort.sv ====
module ahbSlavePort (
  input  logic                   hclk,
  input  logic                   rstN,
  input  ahbSwitchPkg::slaveVecT slaveId,
  ahbReqIf.sink                  reqBus [ahbSwitchPkg::numMasters],
  ahbRspIf.source                rspBus,
  output logic                   hsel,
  output ahbSwitchPkg::addrT     haddr,
  output ahbSwitchPkg::dataT     hwdata,
  output logic                   hwrite,
  output ahbSwitchPkg::sizeT     hsize,
  output ahbSwitchPkg::transT    htrans,
  output logic                   hreadyout,
  input  ahbSwitchPkg::dataT     hrdata,
  input  logic                   hready,
  input  logic                   hresp
);
  import ahbSwitchPkg::*;

  // Gathered master views
  masterVecT reqVec;
  masterVecT switchVec;
  masterVecT mstWrite;
  masterVecT mstReady;
  addrT      mstAddr  [numMasters];
  dataT      mstWdata [numMasters];
  sizeT      mstSize  [numMasters];
  transT     mstTrans [numMasters];

  masterVecT grant;
  logic [masterIdxWidth-1:0] grantIdx;

  // Data phase bookkeeping
  logic                      dataActive;
  logic [masterIdxWidth-1:0] dataOwner;

  for (genvar m = 0; m < numMasters; m++)
  begin : genMaster
    // Request bit for this slave only
    assign reqVec[m]    = |(reqBus[m].req & slaveId);
    assign switchVec[m] = reqBus[m].canSwitch;
    assign mstWrite[m]  = reqBus[m].hwrite;
    assign mstReady[m]  = reqBus[m].hreadyIn;
    assign mstAddr[m]   = reqBus[m].haddr;
    assign mstWdata[m]  = reqBus[m].hwdata;
    assign mstSize[m]   = reqBus[m].hsize;
    assign mstTrans[m]  = reqBus[m].htrans;
  end

  ahbSlaveArbiter uArbiter (
    .hclk      (hclk),
    .rstN      (rstN),
    .req       (reqVec),
    .canSwitch (switchVec),
    .slvReady  (hready),
    .grant     (grant)
  );

  // One-hot grant to index
  always_comb
  begin
    grantIdx = '0;
    for (int m = numMasters - 1; m >= 0; m--)
    begin
      if (grant[m])
        grantIdx = masterIdxWidth'(m);
    end
  end

  //////////////////////////////
  // Address phase mux
  //////////////////////////////

  assign hsel   = reqVec[grantIdx];
  assign haddr  = mstAddr[grantIdx];
  assign hwrite = mstWrite[grantIdx];
  assign hsize  = mstSize[grantIdx];
  // IDLE unless the owner targets us
  assign htrans = hsel ? mstTrans[grantIdx] : transIdle;

  // Slave HREADY follows the data phase owner, else the address owner
  assign hreadyout = dataActive ? mstReady[dataOwner] : mstReady[grantIdx];
  assign hwdata    = mstWdata[dataOwner];

  always_ff @(posedge hclk or negedge rstN)
  begin
    if (!rstN)
    begin
      dataActive <= 1'b0;
      dataOwner  <= '0;
    end
    else if (hreadyout)
    begin
      dataActive <= hsel;
      dataOwner  <= grantIdx;
    end
  end

  // Response back to all master ports
  assign rspBus.hrdata    = hrdata;
  assign rspBus.hreadyout = hready;
  assign rspBus.hresp     = hresp;
  assign rspBus.grant     = grant;

endmodule

// ==== src/ahbSwitch.sv ====
module ahbSwitch (
  input  logic                  hclk,
  input  logic                  rstN,

  // Master side
  input  logic                  mstHsel      [ahbSwitchPkg::numMasters],
  input  ahbSwitchPkg::addrT    mstHaddr     [ahbSwitchPkg::numMasters],
  input  ahbSwitchPkg::dataT    mstHwdata    [ahbSwitchPkg::numMasters],
  input  logic                  mstHwrite    [ahbSwitchPkg::numMasters],
  input  ahbSwitchPkg::sizeT    mstHsize     [ahbSwitchPkg::numMasters],
  input  ahbSwitchPkg::transT   mstHtrans    [ahbSwitchPkg::numMasters],
  input  logic                  mstHready    [ahbSwitchPkg::numMasters],
  output ahbSwitchPkg::dataT    mstHrdata    [ahbSwitchPkg::numMasters],
  output logic                  mstHreadyout [ahbSwitchPkg::numMasters],
  output logic                  mstHresp     [ahbSwitchPkg::numMasters],

  // Slave side
  output logic                  slvHsel      [ahbSwitchPkg::numSlaves],
  output ahbSwitchPkg::addrT    slvHaddr     [ahbSwitchPkg::numSlaves],
  output ahbSwitchPkg::dataT    slvHwdata    [ahbSwitchPkg::numSlaves],
  output logic                  slvHwrite    [ahbSwitchPkg::numSlaves],
  output ahbSwitchPkg::sizeT    slvHsize     [ahbSwitchPkg::numSlaves],
  output ahbSwitchPkg::transT   slvHtrans    [ahbSwitchPkg::numSlaves],
  output logic                  slvHreadyout [ahbSwitchPkg::numSlaves],
  input  ahbSwitchPkg::dataT    slvHrdata    [ahbSwitchPkg::numSlaves],
  input  logic                  slvHready    [ahbSwitchPkg::numSlaves],
  input  logic                  slvHresp     [ahbSwitchPkg::numSlaves]
);
  import ahbSwitchPkg::*;

  // One request bus per master, one response bus per slave
  ahbReqIf reqBus [numMasters] ();
  ahbRspIf rspBus [numSlaves] ();

  //////////////////////////////
  // Master ports
  //////////////////////////////

  for (genvar m = 0; m < numMasters; m++)
  begin : genMaster
    ahbMasterPort uMasterPort (
      .hclk      (hclk),
      .rstN      (rstN),
      .masterId  (masterVecT'(1 << m)),
      .hsel      (mstHsel[m]),
      .haddr     (mstHaddr[m]),
      .hwdata    (mstHwdata[m]),
      .hwrite    (mstHwrite[m]),
      .hsize     (mstHsize[m]),
      .htrans    (mstHtrans[m]),
      .hready    (mstHready[m]),
      .hrdata    (mstHrdata[m]),
      .hreadyout (mstHreadyout[m]),
      .hresp     (mstHresp[m]),
      .reqBus    (reqBus[m]),
      .rspBus    (rspBus)
    );
  end

  //////////////////////////////
  // Slave ports
  //////////////////////////////

  for (genvar s = 0; s < numSlaves; s++)
  begin : genSlave
    ahbSlavePort uSlavePort (
      .hclk      (hclk),
      .rstN      (rstN),
      .slaveId   (slaveVecT'(1 << s)),
      .reqBus    (reqBus),
      .rspBus    (rspBus[s]),
      .hsel      (slvHsel[s]),
      .haddr     (slvHaddr[s]),
      .hwdata    (slvHwdata[s]),
      .hwrite    (slvHwrite[s]),
      .hsize     (slvHsize[s]),
      .htrans    (slvHtrans[s]),
      .hreadyout (slvHreadyout[s]),
      .hrdata    (slvHrdata[s]),
      .hready    (slvHready[s]),
      .hresp     (slvHresp[s])
    );
  end

endmodule

// ==== testbench/tbAhbSlave.sv ====
module tbAhbSlave (
  input  logic                hclk,
  input  logic                rstN,
  input  logic                hsel,
  input  ahbSwitchPkg::addrT  haddr,
  input  ahbSwitchPkg::dataT  hwdata,
  input  logic                hwrite,
  input  ahbSwitchPkg::transT htrans,
  input  logic                hreadyIn,
  output ahbSwitchPkg::dataT  hrdata,
  output logic                hready,
  output logic                hresp
);
  timeunit 1ns;
  timeprecision 1ps;
  import ahbSwitchPkg::*;

  // Feedback taps of a 32-bit Galois LFSR
  localparam logic [31:0] lfsrTaps = 32'h8020_0003;

  // Word memory, indexed by haddr[9:2]
  dataT        mem [256];
  logic [31:0] lfsrQ;

  // Data phase in flight
  logic        dataActive;
  logic        dataWrite;
  logic [7:0]  dataIdx;
  logic [1:0]  waitCnt;

  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
  endfunction

  // Fill pattern spreads the whole index over the word
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0101);
  end

  always @(posedge hclk or negedge rstN)
  begin : slaveSeq
    logic [31:0] step1;
    logic [31:0] step2;
    if (!rstN)
    begin
      lfsrQ      <= 32'h8e1e;
      dataActive <= 1'b0;
      dataWrite  <= 1'b0;
      dataIdx    <= '0;
      waitCnt    <= '0;
    end
    else
    begin
      // Write lands when the data phase completes
      if (dataActive && waitCnt == 0 && dataWrite)
        mem[dataIdx] <= hwdata;
      if (dataActive && waitCnt != 0)
        waitCnt <= waitCnt - 2'd1;
      else if (hreadyIn)
      begin
        dataActive <= hsel && htrans[1];
        if (hsel && htrans[1])
        begin
          // Two LFSR steps, one bit each, give 0 to 3 wait states
          step1 = lfsrStep(lfsrQ);
          step2 = lfsrStep(step1);
          waitCnt   <= {step1[0], step2[0]};
          lfsrQ     <= step2;
          dataWrite <= hwrite;
          dataIdx   <= haddr[9:2];
        end
      end
    end
  end

  assign hready = !dataActive || waitCnt == 0;
  assign hrdata = (dataActive && !dataWrite) ? mem[dataIdx] : '0;
  // Always OKAY
  assign hresp  = 1'b0;

endmodule

// ==== testbench/tbAhbSwitch.sv ====
module tbAhbSwitch;
  timeunit 1ns;
  timeprecision 1ps;
  import ahbSwitchPkg::*;

  // Cycles any single wait may last
  localparam int timeoutCycles = 200;

  logic  hclk;
  logic  rstN;

  logic  mstHsel      [numMasters];
  addrT  mstHaddr     [numMasters];
  dataT  mstHwdata    [numMasters];
  logic  mstHwrite    [numMasters];
  sizeT  mstHsize     [numMasters];
  transT mstHtrans    [numMasters];
  logic  mstHready    [numMasters];
  dataT  mstHrdata    [numMasters];
  logic  mstHreadyout [numMasters];
  logic  mstHresp     [numMasters];

  logic  slvHsel      [numSlaves];
  addrT  slvHaddr     [numSlaves];
  dataT  slvHwdata    [numSlaves];
  logic  slvHwrite    [numSlaves];
  sizeT  slvHsize     [numSlaves];
  transT slvHtrans    [numSlaves];
  logic  slvHreadyout [numSlaves];
  dataT  slvHrdata    [numSlaves];
  logic  slvHready    [numSlaves];
  logic  slvHresp     [numSlaves];

  // Expected memory contents by address
  dataT  sb [addrT];
  // Read data expected on the current data phase
  logic  rdCheck  [numMasters];
  dataT  rdExpect [numMasters];
  // Addresses each slave accepted in arrival order
  addrT  acceptQ [numSlaves][$];
  // Previous-cycle view for the hold checks
  logic  stallPrev [numSlaves];
  addrT  prevAddr  [numSlaves];
  transT prevTrans [numSlaves];
  logic  prevWrite [numSlaves];

  int    errorCount;
  int    stallCount;
  int    passCount;
  int    failCount;

  ahbSwitch dut (.*);

  for (genvar s = 0; s < numSlaves; s++)
  begin : genSlave
    tbAhbSlave uSlave (
      .hclk     (hclk),
      .rstN     (rstN),
      .hsel     (slvHsel[s]),
      .haddr    (slvHaddr[s]),
      .hwdata   (slvHwdata[s]),
      .hwrite   (slvHwrite[s]),
      .htrans   (slvHtrans[s]),
      .hreadyIn (slvHreadyout[s]),
      .hrdata   (slvHrdata[s]),
      .hready   (slvHready[s]),
      .hresp    (slvHresp[s])
    );
  end

  // AHB-Lite master sees its own HREADYOUT as HREADY
  for (genvar m = 0; m < numMasters; m++)
  begin : genMaster
    assign mstHready[m] = mstHreadyout[m];
  end

  initial
  begin
    hclk = 1'b0;
    forever
      #20 hclk = ~hclk;
  end

  //////////////////////////////
  // Reporting helpers
  //////////////////////////////

  task automatic reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
    errorCount++;
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
  endtask

  task automatic reportFailure(string what);
    errorCount++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  task automatic abortOnTimeout(string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic finishTest(string name, int errsBefore);
    if (errorCount == errsBefore)
    begin
      passCount++;
      $display("Test %s: pass", name);
    end
    else
    begin
      failCount++;
      $display("Test %s: fail with %0d errors", name, errorCount - errsBefore);
    end
  endtask

  //////////////////////////////
  // Bus checker
  //////////////////////////////

  // Sample at the negedge where inputs and registers have settled
  always @(negedge hclk)
  begin : busChecker
    if (rstN)
    begin
      for (int s = 0; s < numSlaves; s++)
      begin
        // Decode lands only in this slave's region
        if (slvHsel[s])
          assert ((slvHaddr[s] & slaveMask[s]) == (slaveBase[s] & slaveMask[s]))
          else reportMismatch($sformatf("slvHaddr[%0d]", s), slaveBase[s],
                              slvHaddr[s] & slaveMask[s]);
        assert (slvHsel[s] || slvHtrans[s] == transIdle)
        else reportMismatch($sformatf("slvHtrans[%0d]", s), transIdle, slvHtrans[s]);
        // Address phase holds through a wait state
        if (stallPrev[s])
        begin
          assert (slvHaddr[s] == prevAddr[s])
          else reportMismatch($sformatf("slvHaddr[%0d]", s), prevAddr[s], slvHaddr[s]);
          assert (slvHtrans[s] == prevTrans[s])
          else reportMismatch($sformatf("slvHtrans[%0d]", s), prevTrans[s], slvHtrans[s]);
          assert (slvHwrite[s] == prevWrite[s])
          else reportMismatch($sformatf("slvHwrite[%0d]", s), prevWrite[s], slvHwrite[s]);
        end
        if (!slvHready[s])
        begin
          stallCount++;
          // Stall reaches the owning master and comes back as slave HREADY
          assert (!slvHreadyout[s])
          else reportMismatch($sformatf("slvHreadyout[%0d]", s), 0, slvHreadyout[s]);
          assert (!(mstHreadyout[0] && mstHreadyout[1]))
          else reportFailure($sformatf("slave %0d waits but no master is stalled", s));
        end
        if (slvHsel[s] && slvHtrans[s][1] && slvHreadyout[s])
        begin
          // Every master task moves whole words
          assert (slvHsize[s] == 3'b010)
          else reportMismatch($sformatf("slvHsize[%0d]", s), 3'b010, slvHsize[s]);
          acceptQ[s].push_back(slvHaddr[s]);
        end
        stallPrev[s] = !slvHready[s];
        prevAddr[s]  = slvHaddr[s];
        prevTrans[s] = slvHtrans[s];
        prevWrite[s] = slvHwrite[s];
      end
      for (int m = 0; m < numMasters; m++)
      begin
        assert (mstHresp[m] == 1'b0)
        else reportMismatch($sformatf("mstHresp[%0d]", m), 0, mstHresp[m]);
        if (rdCheck[m] && mstHreadyout[m])
          assert (mstHrdata[m] == rdExpect[m])
          else reportMismatch($sformatf("mstHrdata[%0d]", m), rdExpect[m], mstHrdata[m]);
      end
    end
  end

  //////////////////////////////
  // Master tasks
  //////////////////////////////

  // Returns 2 ns after the edge where HREADYOUT was high
  task automatic waitReady(int m, string what);
    int cnt;
    cnt = 0;
    @(negedge hclk);
    while (!mstHreadyout[m] && cnt < timeoutCycles)
    begin
      @(negedge hclk);
      cnt++;
    end
    if (!mstHreadyout[m])
      abortOnTimeout($sformatf("master %0d %s", m, what));
    else
    begin
      @(posedge hclk);
      #2;
    end
  endtask

  task automatic driveAddr(int m, addrT a, logic wr, transT t);
    mstHsel[m]   = 1'b1;
    mstHaddr[m]  = a;
    mstHwrite[m] = wr;
    mstHsize[m]  = 3'b010;
    mstHtrans[m] = t;
  endtask

  task automatic driveIdle(int m);
    mstHsel[m]   = 1'b0;
    mstHtrans[m] = transIdle;
  endtask

  // Distinct data per master and address
  function automatic dataT dataFor(int m, addrT a);
    return a ^ {8'(m + 1), 24'h5c_3a71};
  endfunction

  task automatic writeWord(int m, addrT a, dataT d);
    driveAddr(m, a, 1'b1, transNonSeq);
    waitReady(m, "write address");
    driveIdle(m);
    mstHwdata[m] = d;
    sb[a] = d;
    waitReady(m, "write data");
  endtask

  task automatic readWord(int m, addrT a);
    driveAddr(m, a, 1'b0, transNonSeq);
    waitReady(m, "read address");
    driveIdle(m);
    rdExpect[m] = sb[a];
    rdCheck[m]  = 1'b1;
    waitReady(m, "read data");
    rdCheck[m]  = 1'b0;
  endtask

  // INCR4 write where beat i data rides with the beat i+1 address
  task automatic writeBurst(int m, addrT a, dataT d0);
    for (int i = 0; i < 4; i++)
    begin
      driveAddr(m, a + 4 * i, 1'b1, (i == 0) ? transNonSeq : transSeq);
      if (i > 0)
        mstHwdata[m] = d0 + i - 1;
      waitReady(m, "burst beat");
      sb[a + 4 * i] = d0 + i;
    end
    driveIdle(m);
    mstHwdata[m] = d0 + 3;
    waitReady(m, "burst last data");
  endtask

  task automatic expectOrder(int s, addrT exp[$]);
    assert (acceptQ[s].size() == exp.size())
    else reportMismatch($sformatf("slave %0d accept count", s), exp.size(), acceptQ[s].size());
    for (int i = 0; i < exp.size() && i < acceptQ[s].size(); i++)
      assert (acceptQ[s][i] == exp[i])
      else reportMismatch($sformatf("slvHaddr[%0d]", s), exp[i], acceptQ[s][i]);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin : mainSeq
    int errs;
    addrT a0;
    addrT a1;
    errorCount = 0;
    stallCount = 0;
    passCount  = 0;
    failCount  = 0;
    rstN = 1'b0;
    for (int m = 0; m < numMasters; m++)
    begin
      mstHsel[m]   = 1'b0;
      mstHaddr[m]  = '0;
      mstHwdata[m] = '0;
      mstHwrite[m] = 1'b0;
      mstHsize[m]  = 3'b010;
      mstHtrans[m] = transIdle;
      rdCheck[m]   = 1'b0;
      rdExpect[m]  = '0;
    end
    for (int s = 0; s < numSlaves; s++)
      stallPrev[s] = 1'b0;
    repeat (16) @(posedge hclk);
    #2 rstN = 1'b1;

    // Idle bus after reset
    errs = errorCount;
    @(negedge hclk);
    for (int m = 0; m < numMasters; m++)
      assert (mstHreadyout[m])
      else reportMismatch($sformatf("mstHreadyout[%0d]", m), 1, mstHreadyout[m]);
    for (int s = 0; s < numSlaves; s++)
      assert (!slvHsel[s] && slvHtrans[s] == transIdle)
      else reportMismatch($sformatf("slvHsel[%0d]", s), 0, slvHsel[s]);
    @(posedge hclk);
    #2;
    finishTest("reset", errs);

    // Every master to every slave
    errs = errorCount;
    for (int m = 0; m < numMasters; m++)
      for (int s = 0; s < numSlaves; s++)
      begin
        a0 = slaveBase[s] + 32'h100 + m * 32'h40;
        writeWord(m, a0, dataFor(m, a0));
        readWord(m, a0);
      end
    finishTest("writeRead", errs);

    // Each master to its own slave
    // Each slave sees only its own transfer
    errs = errorCount;
    acceptQ[0].delete();
    acceptQ[1].delete();
    a0 = slaveBase[0] + 32'h80;
    a1 = slaveBase[1] + 32'h80;
    fork
      writeWord(0, a0, dataFor(0, a0));
      writeWord(1, a1, dataFor(1, a1));
    join
    expectOrder(0, '{a0});
    expectOrder(1, '{a1});
    finishTest("decode", errs);

    // Slave 0 stays parked on master 0 since the decode test
    // Master 0 wins the same-cycle race for it
    errs = errorCount;
    acceptQ[0].delete();
    a0 = slaveBase[0] + 32'h200;
    a1 = slaveBase[0] + 32'h204;
    fork
      writeWord(0, a0, dataFor(0, a0));
      writeWord(1, a1, dataFor(1, a1));
    join
    expectOrder(0, '{a0, a1});
    fork
      readWord(0, a1);
      readWord(1, a0);
    join
    finishTest("contention", errs);

    // Master 0 must wait out the whole burst
    errs = errorCount;
    acceptQ[1].delete();
    a0 = slaveBase[1] + 32'h340;
    a1 = slaveBase[1] + 32'h300;
    fork
      writeBurst(1, a1, 32'hb0a5_0000);
      begin
        repeat (3) @(posedge hclk);
        #2;
        writeWord(0, a0, dataFor(0, a0));
      end
    join
    expectOrder(1, '{a1, a1 + 4, a1 + 8, a1 + 12, a0});
    for (int i = 0; i < 4; i++)
      readWord(0, a1 + 4 * i);
    readWord(1, a0);
    finishTest("burst", errs);

    // Back-to-back reads to draw wait states
    errs = errorCount;
    stallCount = 0;
    for (int i = 0; i < 8; i++)
      readWord(i % 2, slaveBase[i % 2] + 32'h100);
    assert (stallCount > 0)
    else reportFailure("no wait state was seen on any slave");
    finishTest("waitStates", errs);

    $display("Tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errorCount);
    if (failCount == 0 && errorCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sim.f ====
src/ahbSwitchPkg.sv
src/ahbReqIf.sv
src/ahbRspIf.sv
src/ahbSlaveArbiter.sv
src/ahbMasterPort.sv
src/ahbSlavePort.sv
src/ahbSwitch.sv
testbench/tbAhbSlave.sv
testbench/tbAhbSwitch.sv
